// File: rtl/emu_pkg.sv
package emu_pkg;

    ////////////////////////////////////////
    // Plain vectors

    // Host status word from the HPS side
    typedef logic [31:0] status_t;

    // Two DB15 mode bits taken from status
    typedef logic [1:0]  db15_mode_t;

    // Open drain user port
    typedef logic [6:0]  user_port_t;

    // Raw adapter frame, active low on the wire
    typedef logic [15:0] db15_word_t;

    // Bit positions in status and on the user port
    localparam int STATUS_RST_BIT  = 0;
    localparam int STATUS_MODE_LSB = 30;
    localparam int USER_JOY_LOAD   = 0;
    localparam int USER_JOY_CLK    = 1;
    localparam int USER_JOY_DATA   = 5;

    ////////////////////////////////////////
    // Player pads

    // One player, every field active high
    typedef struct packed {
        logic coin;
        logic start;
        logic b2;
        logic b1;
        logic right;
        logic left;
        logic down;
        logic up;
    } pad_t;

    // Both adapter pads plus the slot enables
    typedef struct packed {
        logic p2_active;
        logic p1_active;
        pad_t p2;
        pad_t p1;
    } db15_pads_t;

    // Adapter scan FSM
    typedef enum logic [1:0] {
        DB_IDLE,
        DB_LOAD,
        DB_CLK_LO,
        DB_CLK_HI
    } db15_state_t;

endpackage

// File: rtl/sys_reset_ctrl.sv
`timescale 1ns/10ps

module sys_reset_ctrl #(
    parameter int PLL_RST_CYCLES  = 256,
    parameter int GAME_RST_CYCLES = 16
) (
    input  logic clk_sys,
    input  logic RESET,
    input  logic pll_locked,
    input  logic status_rst,
    input  logic button_rst,
    output logic pll_rst,
    output logic game_rst
);

    localparam int PW = $clog2(PLL_RST_CYCLES + 1);
    localparam int GW = $clog2(GAME_RST_CYCLES + 1);

    localparam logic [PW-1:0] PLL_LOAD  = PW'(PLL_RST_CYCLES - 1);
    localparam logic [GW-1:0] GAME_LOAD = GW'(GAME_RST_CYCLES - 1);

    logic          last_locked;
    logic          lock_lost;
    logic [PW-1:0] pll_cnt;
    logic          rst_cause;
    logic [GW-1:0] game_cnt;

    ////////////////////////////////////////
    // PLL re-lock request

    // Falling edge of the lock flag
    assign lock_lost = last_locked & ~pll_locked;

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            last_locked <= 1'b0;
            pll_rst     <= 1'b0;
            pll_cnt     <= '0;
        end else begin
            last_locked <= pll_locked;
            if (lock_lost) begin
                // Another loss while holding restarts the hold
                pll_rst <= 1'b1;
                pll_cnt <= PLL_LOAD;
            end else if (pll_cnt != '0) begin
                pll_cnt <= pll_cnt - PW'(1);
            end else begin
                pll_rst <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Game reset stretcher

    // Anything that must keep the core frozen
    assign rst_cause = status_rst | button_rst | pll_rst | ~pll_locked;

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            game_rst <= 1'b1;
            game_cnt <= GAME_LOAD;
        end else if (rst_cause) begin
            game_rst <= 1'b1;
            game_cnt <= GAME_LOAD;
        end else if (game_cnt != '0) begin
            game_cnt <= game_cnt - GW'(1);
        end else begin
            game_rst <= 1'b0;
        end
    end

endmodule

// File: rtl/db15_joy_reader.sv
`timescale 1ns/10ps

module db15_joy_reader import emu_pkg::*; #(
    parameter int JOY_HALF_BIT = 4,
    parameter int SCAN_PERIOD  = 256
) (
    input  logic       clk_sys,
    input  logic       RESET,
    input  db15_mode_t mode,
    input  user_port_t user_in,
    output user_port_t user_out,
    output logic       user_mode,
    output db15_pads_t pads,
    output logic       joy_update
);

    localparam int PW = $clog2(SCAN_PERIOD);
    localparam int HW = $clog2(2 * JOY_HALF_BIT);

    localparam logic [PW-1:0] PERIOD_LAST = PW'(SCAN_PERIOD - 1);
    localparam logic [HW-1:0] LOAD_LAST   = HW'(2 * JOY_HALF_BIT - 1);
    localparam logic [HW-1:0] HALF_LAST   = HW'(JOY_HALF_BIT - 1);

    db15_state_t   state;
    logic [PW-1:0] period_cnt;
    logic [HW-1:0] half_cnt;
    logic [3:0]    bit_idx;
    db15_word_t    shift_word;
    logic          scan_en;
    logic          sample_now;
    logic          last_sample;
    logic          joy_load;
    logic          joy_clk;
    logic          joy_data;
    pad_t          pad1;
    pad_t          pad2;

    assign scan_en  = |mode;
    assign joy_data = user_in[USER_JOY_DATA];

    ////////////////////////////////////////
    // Frame timing

    // Free running while enabled, frame starts at zero
    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            period_cnt <= '0;
        end else if (!scan_en || period_cnt == PERIOD_LAST) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + PW'(1);
        end
    end

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            state    <= DB_IDLE;
            half_cnt <= '0;
            bit_idx  <= '0;
        end else if (!scan_en) begin
            // Abort any frame and release the port
            state    <= DB_IDLE;
            half_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            case (state)
                DB_IDLE: begin
                    if (period_cnt == '0) begin
                        state    <= DB_LOAD;
                        half_cnt <= '0;
                    end
                end
                DB_LOAD: begin
                    if (half_cnt == LOAD_LAST) begin
                        state    <= DB_CLK_LO;
                        half_cnt <= '0;
                        bit_idx  <= '0;
                    end else begin
                        half_cnt <= half_cnt + HW'(1);
                    end
                end
                DB_CLK_LO: begin
                    if (half_cnt == HALF_LAST) begin
                        state    <= DB_CLK_HI;
                        half_cnt <= '0;
                    end else begin
                        half_cnt <= half_cnt + HW'(1);
                    end
                end
                DB_CLK_HI: begin
                    if (half_cnt == HALF_LAST) begin
                        half_cnt <= '0;
                        if (bit_idx == 4'd15) begin
                            state <= DB_IDLE;
                        end else begin
                            state   <= DB_CLK_LO;
                            bit_idx <= bit_idx + 4'd1;
                        end
                    end else begin
                        half_cnt <= half_cnt + HW'(1);
                    end
                end
                default: state <= DB_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // Data capture

    // Same cycle the clock goes high
    assign sample_now = scan_en && (state == DB_CLK_LO) && (half_cnt == HALF_LAST);

    // Bit 0 arrives first and ends up at the bottom
    always_ff @(posedge clk_sys) begin
        if (sample_now) begin
            shift_word <= {joy_data, shift_word[15:1]};
        end
    end

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            last_sample <= 1'b0;
            joy_update  <= 1'b0;
            pad1        <= '0;
            pad2        <= '0;
        end else begin
            last_sample <= sample_now && (bit_idx == 4'd15);
            joy_update  <= last_sample;
            if (last_sample) begin
                pad1 <= pad_t'(~shift_word[7:0]);
                pad2 <= pad_t'(~shift_word[15:8]);
            end
        end
    end

    ////////////////////////////////////////
    // Port drive

    // Load is active low
    assign joy_load = (state != DB_LOAD);
    assign joy_clk  = (state == DB_CLK_HI);

    always_comb begin
        user_out = '1;
        if (scan_en) begin
            user_out[USER_JOY_CLK]  = joy_clk;
            user_out[USER_JOY_LOAD] = joy_load;
        end
    end

    assign user_mode = scan_en;

    assign pads = '{p2_active: mode[1], p1_active: scan_en, p2: pad2, p1: pad1};

endmodule

// File: rtl/joy_select.sv
`timescale 1ns/10ps

module joy_select import emu_pkg::*; (
    input  logic       clk_sys,
    input  logic       RESET,
    input  pad_t       host_joy1,
    input  pad_t       host_joy2,
    input  db15_pads_t pads,
    output pad_t       game_joy1,
    output pad_t       game_joy2
);

    pad_t next_joy1;
    pad_t next_joy2;

    // Whole pad is taken from one source so coin and start
    // always belong to the same player
    function automatic pad_t pick_pad(
        input logic use_db15,
        input pad_t db15_pad,
        input pad_t host_pad
    );
        pad_t sel;
        if (use_db15) begin
            sel = db15_pad;
        end else begin
            sel = host_pad;
        end
        return sel;
    endfunction

    ////////////////////////////////////////
    // Slot choice

    always_comb begin
        next_joy1 = pick_pad(pads.p1_active, pads.p1, host_joy1);
        next_joy2 = pick_pad(pads.p2_active, pads.p2, host_joy2);
    end

    ////////////////////////////////////////
    // Output registers

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            game_joy1 <= '0;
            game_joy2 <= '0;
        end else begin
            game_joy1 <= next_joy1;
            game_joy2 <= next_joy2;
        end
    end

endmodule

// File: rtl/emu_top.sv
`timescale 1ns/10ps

module emu_top import emu_pkg::*; #(
    parameter int PLL_RST_CYCLES  = 256,
    parameter int GAME_RST_CYCLES = 16,
    parameter int JOY_HALF_BIT    = 4,
    parameter int SCAN_PERIOD     = 256
) (
    input  logic       clk_sys,
    input  logic       RESET,

    // PLL
    input  logic       pll_locked,
    output logic       pll_rst,

    // Host side
    input  status_t    status,
    input  logic [1:0] buttons,
    input  pad_t       host_joy1,
    input  pad_t       host_joy2,

    // User port
    input  user_port_t user_in,
    output user_port_t user_out,
    output logic       user_mode,

    // Game core side
    output logic       game_rst,
    output pad_t       game_joy1,
    output pad_t       game_joy2,
    output logic       joy_update
);

    logic       status_rst;
    logic       button_rst;
    db15_mode_t db15_mode;
    db15_pads_t db15_pads;

    assign status_rst = status[STATUS_RST_BIT];
    assign button_rst = buttons[1];
    assign db15_mode  = status[STATUS_MODE_LSB +: 2];

    ////////////////////////////////////////
    // Reset supervision

    sys_reset_ctrl #(
        .PLL_RST_CYCLES  ( PLL_RST_CYCLES  ),
        .GAME_RST_CYCLES ( GAME_RST_CYCLES )
    ) u_rst (
        .clk_sys    ( clk_sys    ),
        .RESET      ( RESET      ),
        .pll_locked ( pll_locked ),
        .status_rst ( status_rst ),
        .button_rst ( button_rst ),
        .pll_rst    ( pll_rst    ),
        .game_rst   ( game_rst   )
    );

    ////////////////////////////////////////
    // DB15 adapter

    db15_joy_reader #(
        .JOY_HALF_BIT ( JOY_HALF_BIT ),
        .SCAN_PERIOD  ( SCAN_PERIOD  )
    ) u_db15 (
        .clk_sys    ( clk_sys    ),
        .RESET      ( RESET      ),
        .mode       ( db15_mode  ),
        .user_in    ( user_in    ),
        .user_out   ( user_out   ),
        .user_mode  ( user_mode  ),
        .pads       ( db15_pads  ),
        .joy_update ( joy_update )
    );

    ////////////////////////////////////////
    // Player slots

    joy_select u_joy (
        .clk_sys   ( clk_sys   ),
        .RESET     ( RESET     ),
        .host_joy1 ( host_joy1 ),
        .host_joy2 ( host_joy2 ),
        .pads      ( db15_pads ),
        .game_joy1 ( game_joy1 ),
        .game_joy2 ( game_joy2 )
    );

endmodule

// File: sim/emu_props.sv
`timescale 1ns/10ps

module emu_props import emu_pkg::*; (
    input logic       clk_sys,
    input logic       RESET,
    input logic       pll_locked,
    input logic       pll_rst,
    input logic       game_rst,
    input user_port_t user_out
);

    ////////////////////////////////////////
    // Reset supervision

    // Re-lock only after the lock flag fell
    pll_rst_cause: assert property (
        @(posedge clk_sys) disable iff (RESET)
        $rose(pll_rst) |-> ($past(pll_locked, 2) && !$past(pll_locked))
    ) else $error("pll_rst rose without a preceding lock loss");

    game_rst_covers_pll: assert property (
        @(posedge clk_sys) disable iff (RESET)
        pll_rst |-> game_rst
    ) else $error("game_rst low while pll_rst is high");

    ////////////////////////////////////////
    // User port

    // No clock pulse during the load phase
    clk_quiet_in_load: assert property (
        @(posedge clk_sys) disable iff (RESET)
        !user_out[USER_JOY_LOAD] |-> !user_out[USER_JOY_CLK]
    ) else $error("adapter clock high while load is low");

endmodule

// Port rules hold trivially in the reset instance
bind sys_reset_ctrl emu_props rst_props (
    .clk_sys    ( clk_sys    ),
    .RESET      ( RESET      ),
    .pll_locked ( pll_locked ),
    .pll_rst    ( pll_rst    ),
    .game_rst   ( game_rst   ),
    .user_out   ( 7'h7f      )
);

// Reset rules idle in the reader instance
bind db15_joy_reader emu_props port_props (
    .clk_sys    ( clk_sys    ),
    .RESET      ( RESET      ),
    .pll_locked ( 1'b1       ),
    .pll_rst    ( 1'b0       ),
    .game_rst   ( 1'b1       ),
    .user_out   ( user_out   )
);

// File: sim/tb_emu.sv
`timescale 1ns/10ps

module tb_emu import emu_pkg::*; ();

    localparam int PLL_RST_CYCLES  = 256;
    localparam int GAME_RST_CYCLES = 16;
    localparam int JOY_HALF_BIT    = 4;
    localparam int SCAN_PERIOD     = 256;
    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 8;
    localparam int DB15_WORDS      = 3;
    localparam int WATCHDOG_CYCLES = 20 * SCAN_PERIOD + 2000;

    localparam logic [31:0] SEED      = 32'hec690a7d;
    localparam user_port_t  PORT_IDLE = 7'h7f;

    logic       clk_sys = 1'b0;
    logic       RESET;
    logic       pll_locked;
    logic       pll_rst;
    status_t    status;
    logic [1:0] buttons;
    pad_t       host_joy1;
    pad_t       host_joy2;
    user_port_t user_in;
    user_port_t user_out;
    logic       user_mode;
    logic       game_rst;
    pad_t       game_joy1;
    pad_t       game_joy2;
    logic       joy_update;

    // Adapter model state, index 16 means frame done
    db15_word_t adapter_word;
    logic [4:0] adapter_idx = 5'd16;
    logic       adapter_clk_q = 1'b0;

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    emu_top #(
        .PLL_RST_CYCLES  ( PLL_RST_CYCLES  ),
        .GAME_RST_CYCLES ( GAME_RST_CYCLES ),
        .JOY_HALF_BIT    ( JOY_HALF_BIT    ),
        .SCAN_PERIOD     ( SCAN_PERIOD     )
    ) dut0 (.*);

    ////////////////////////////////////////
    // DB15 adapter model

    // Serial data on bit 5, idle high past the last bit
    assign user_in = {1'b1, adapter_idx[4] ? 1'b1 : adapter_word[adapter_idx[3:0]], 5'b11111};

    always @(negedge clk_sys) begin
        if (status[STATUS_MODE_LSB +: 2] != 2'b00) begin
            if (!user_out[USER_JOY_LOAD]) begin
                adapter_idx = 5'd0;
            end else if (user_out[USER_JOY_CLK] && !adapter_clk_q && !adapter_idx[4]) begin
                adapter_idx = adapter_idx + 5'd1;
            end
            adapter_clk_q = user_out[USER_JOY_CLK];
        end
    end

    ////////////////////////////////////////
    // Checks

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_pad(input string test, input pad_t exp, input pad_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", test, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_bit(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", test, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_port(input string test, input user_port_t exp, input user_port_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", test, exp, act);
            abort_run();
        end
    endtask

    ////////////////////////////////////////
    // Helpers

    function automatic pad_t random_pad();
        return pad_t'(8'($urandom()));
    endfunction

    // Wire bits are active low
    function automatic pad_t wire_to_pad(input logic [7:0] wire_bits);
        return pad_t'(~wire_bits);
    endfunction

    // High for the stretch, low on its last cycle
    task automatic check_game_release(input string test);
        for (int i = 1; i <= GAME_RST_CYCLES; i++) begin
            @(negedge clk_sys);
            compare_bit(test, logic'(i < GAME_RST_CYCLES), game_rst);
        end
    endtask

    task automatic wait_updates(input int count);
        for (int n = 0; n < count; n++) begin
            @(negedge clk_sys);
            while (joy_update !== 1'b1) begin
                @(negedge clk_sys);
            end
        end
    endtask

    task automatic hold_request(input string test, input logic via_button);
        compare_bit(test, 1'b0, game_rst);
        if (via_button) begin
            buttons[1] = 1'b1;
        end else begin
            status[STATUS_RST_BIT] = 1'b1;
        end
        repeat (6) begin
            @(negedge clk_sys);
            compare_bit(test, 1'b1, game_rst);
        end
        buttons[1] = 1'b0;
        status[STATUS_RST_BIT] = 1'b0;
        check_game_release(test);
    endtask

    ////////////////////////////////////////
    // Tests

    task automatic test_power_on();
        string name = "power_on";
        repeat (RESET_CYCLES) @(negedge clk_sys);
        compare_bit(name, 1'b0, pll_rst);
        compare_bit(name, 1'b1, game_rst);
        compare_bit(name, 1'b0, joy_update);
        compare_port(name, PORT_IDLE, user_out);
        compare_pad(name, '0, game_joy1);
        compare_pad(name, '0, game_joy2);
        RESET = 1'b0;
        check_game_release(name);
        compare_bit(name, 1'b0, pll_rst);
    endtask

    task automatic test_lock_loss();
        string name = "lock_loss";
        pll_locked = 1'b0;
        for (int i = 1; i <= PLL_RST_CYCLES; i++) begin
            @(negedge clk_sys);
            compare_bit(name, 1'b1, pll_rst);
            compare_bit(name, 1'b1, game_rst);
            if (i == 4) begin
                pll_locked = 1'b1;
            end
        end
        @(negedge clk_sys);
        compare_bit(name, 1'b0, pll_rst);
        compare_bit(name, 1'b1, game_rst);
        check_game_release(name);
    endtask

    task automatic test_reset_request();
        hold_request("status_reset", 1'b0);
        hold_request("button_reset", 1'b1);
    endtask

    task automatic test_host_passthrough();
        string name = "mode0_passthrough";
        status[STATUS_MODE_LSB +: 2] = 2'b00;
        for (int i = 0; i < 8; i++) begin
            host_joy1 = random_pad();
            host_joy2 = random_pad();
            @(negedge clk_sys);
            compare_pad(name, host_joy1, game_joy1);
            compare_pad(name, host_joy2, game_joy2);
            compare_port(name, PORT_IDLE, user_out);
            compare_bit(name, 1'b0, user_mode);
        end
    endtask

    task automatic test_one_player();
        string      name = "db15_one_player";
        db15_word_t word;
        host_joy1 = random_pad();
        host_joy2 = random_pad();
        status[STATUS_MODE_LSB +: 2] = 2'b01;
        for (int i = 0; i < DB15_WORDS; i++) begin
            word = 16'($urandom());
            adapter_word = word;
            // First frame may be split across the word change
            wait_updates(2);
            @(negedge clk_sys);
            compare_pad(name, wire_to_pad(word[7:0]), game_joy1);
            compare_pad(name, host_joy2, game_joy2);
            compare_bit(name, 1'b1, user_mode);
            compare_port(name, PORT_IDLE, user_out | 7'b0000011);
        end
    endtask

    task automatic test_two_player();
        string      name = "db15_two_player";
        db15_word_t word;
        for (int i = 0; i < DB15_WORDS; i++) begin
            // Modes 2 and 3 both mean two players
            status[STATUS_MODE_LSB +: 2] = {1'b1, i[0]};
            word = 16'($urandom());
            adapter_word = word;
            wait_updates(2);
            @(negedge clk_sys);
            compare_pad(name, wire_to_pad(word[7:0]), game_joy1);
            compare_pad(name, wire_to_pad(word[15:8]), game_joy2);
            compare_bit(name, 1'b1, user_mode);
        end
        status[STATUS_MODE_LSB +: 2] = 2'b00;
        host_joy1 = random_pad();
        host_joy2 = random_pad();
        @(negedge clk_sys);
        compare_pad(name, host_joy1, game_joy1);
        compare_pad(name, host_joy2, game_joy2);
        compare_port(name, PORT_IDLE, user_out);
        compare_bit(name, 1'b0, user_mode);
    endtask

    ////////////////////////////////////////
    // Sequence and watchdog

    initial begin
        void'($urandom(SEED));
        RESET        = 1'b1;
        pll_locked   = 1'b1;
        status       = '0;
        buttons      = '0;
        host_joy1    = '0;
        host_joy2    = '0;
        adapter_word = '1;

        test_power_on();
        test_lock_loss();
        test_reset_request();
        test_host_passthrough();
        test_one_player();
        test_two_player();

        $display("Simulation passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        abort_run();
    end

endmodule

// File: vlog.f
rtl/emu_pkg.sv
rtl/sys_reset_ctrl.sv
rtl/db15_joy_reader.sv
rtl/joy_select.sv
rtl/emu_top.sv
sim/emu_props.sv
sim/tb_emu.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_emu -Mdir obj_dir -f vlog.f

status=0
./obj_dir/Vtb_emu > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "FAIL"
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    echo "FAIL: run ended without a result, exit status $status"
    exit 1
fi
echo "PASS"
